// File: obi_pkg.sv
// OBI bus types and slow RAM timing shared by every bus user
// Byte addressing, 32-bit data, one outstanding transaction per master
package obi_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] word_t;
  typedef logic [3:0]  be_t;

  // RAM depth in words, indexed by addr[8:2]
  localparam int unsigned MEM_WORDS = 128;

  // Cycles req is held before gnt
  localparam int unsigned MEM_GNT_WAIT = 2;

  // Cycles from grant edge to rvalid
  localparam int unsigned MEM_RVALID_WAIT = 3;

  // Arbiter masters
  localparam int unsigned NUM_MASTERS = 2;
  localparam int unsigned HOST_IDX    = 0;
  localparam int unsigned COPY_IDX    = 1;

endpackage

// File: memcopy_pkg.sv
// Register map and engine states of the memory copy peripheral
// Offsets are byte offsets on the register port, full-word access only
package memcopy_pkg;

  typedef logic [3:0] reg_addr_t;

  localparam reg_addr_t REG_SRC    = 4'h0;
  localparam reg_addr_t REG_DST    = 4'h4;
  // Writing the word count starts a copy
  localparam reg_addr_t REG_SIZE   = 4'h8;
  // Bit 0 busy, bit 1 done; a read clears done
  localparam reg_addr_t REG_STATUS = 4'hC;

  typedef enum logic [2:0] {
    IDLE,
    RD_REQ,
    RD_WAIT,
    WR_REQ,
    WR_WAIT
  } copy_state_e;

endpackage

// File: obi_if.sv
// OBI request and response signals for one master/slave link
// Request fields stay stable from req until gnt
`timescale 1ns/1ps

interface obi_if
  import obi_pkg::*;
();

  // Request channel
  logic  req;
  logic  we;
  be_t   be;
  addr_t addr;
  word_t wdata;

  // Response channel
  logic  gnt;
  logic  rvalid;
  word_t rdata;

  modport master (output req, we, be, addr, wdata, input gnt, rvalid, rdata);
  modport slave  (input req, we, be, addr, wdata, output gnt, rvalid, rdata);

endinterface

// File: slow_memory.sv
// Single-port RAM with fixed grant and response delays
// Only one transaction in flight; no grant while a response is pending
`timescale 1ns/1ps

module slow_memory
  import obi_pkg::*;
(
  input  logic clk_i,
  input  logic reset_i,
  obi_if.slave bus_i
);

  word_t mem_q [MEM_WORDS];
  word_t rdata_q;
  logic  pend_q;
  logic  rvalid_q;
  logic  [3:0] cnt_q;
  logic  [$clog2(MEM_WORDS)-1:0] idx;

  assign idx = bus_i.addr[8:2];

  // Grant in the MEM_GNT_WAIT-th cycle of a held request
  assign bus_i.gnt    = bus_i.req && !pend_q && (cnt_q == 4'(MEM_GNT_WAIT - 1));
  assign bus_i.rvalid = rvalid_q;
  assign bus_i.rdata  = rdata_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pend_q   <= 1'b0;
      rvalid_q <= 1'b0;
      cnt_q    <= '0;
    end else if (!pend_q) begin
      if (bus_i.gnt) begin
        pend_q <= 1'b1;
        cnt_q  <= 4'd1;
      end else if (bus_i.req) begin
        cnt_q <= cnt_q + 4'd1;
      end else begin
        cnt_q <= '0;
      end
    end else if (rvalid_q) begin
      // Response taken, ready for the next request
      pend_q   <= 1'b0;
      rvalid_q <= 1'b0;
      cnt_q    <= '0;
    end else if (cnt_q == 4'(MEM_RVALID_WAIT)) begin
      rvalid_q <= 1'b1;
    end else begin
      cnt_q <= cnt_q + 4'd1;
    end
  end

  // Array and read data are sampled at the grant edge
  always_ff @(posedge clk_i) begin
    if (bus_i.gnt) begin
      if (bus_i.we) begin
        for (int b = 0; b < 4; b++) begin
          if (bus_i.be[b]) begin
            mem_q[idx][8*b +: 8] <= bus_i.wdata[8*b +: 8];
          end
        end
      end else begin
        rdata_q <= mem_q[idx];
      end
    end
  end

  // Each response belongs to the grant MEM_RVALID_WAIT edges before it
  a_rvalid_pending: assert property (
    @(posedge clk_i) disable iff (reset_i)
    $rose(bus_i.rvalid) |-> $past(bus_i.gnt, MEM_RVALID_WAIT + 1)
  ) else $error("rvalid raised without a matching grant");

endmodule

// File: obi_arbiter.sv
// Two-master round-robin arbiter in front of one OBI slave
// A forwarded request keeps its master until granted; one response in flight
`timescale 1ns/1ps

module obi_arbiter
  import obi_pkg::*;
(
  input  logic  clk_i,
  input  logic  reset_i,
  obi_if.slave  host_i,
  obi_if.slave  copy_i,
  obi_if.master mem_o
);

  typedef logic [$clog2(NUM_MASTERS)-1:0] mst_idx_t;

  logic [NUM_MASTERS-1:0] req_v;
  mst_idx_t sel;
  mst_idx_t last_q;
  mst_idx_t owner_q;
  mst_idx_t wait_idx_q;
  logic     wait_q;
  logic     pend_q;
  logic     host_sel;
  logic     host_own;

  assign req_v[HOST_IDX] = host_i.req;
  assign req_v[COPY_IDX] = copy_i.req;

  always_comb begin
    if (wait_q) begin
      sel = wait_idx_q;
    end else if (&req_v) begin
      // Tie goes to the master not granted last
      sel = ~last_q;
    end else if (req_v[COPY_IDX]) begin
      sel = mst_idx_t'(COPY_IDX);
    end else begin
      sel = mst_idx_t'(HOST_IDX);
    end
  end

  assign host_sel = (sel == mst_idx_t'(HOST_IDX));
  assign host_own = (owner_q == mst_idx_t'(HOST_IDX));

  assign mem_o.req   = req_v[sel] && !pend_q;
  assign mem_o.we    = host_sel ? host_i.we    : copy_i.we;
  assign mem_o.be    = host_sel ? host_i.be    : copy_i.be;
  assign mem_o.addr  = host_sel ? host_i.addr  : copy_i.addr;
  assign mem_o.wdata = host_sel ? host_i.wdata : copy_i.wdata;

  assign host_i.gnt    = mem_o.gnt && host_sel;
  assign copy_i.gnt    = mem_o.gnt && !host_sel;
  assign host_i.rvalid = mem_o.rvalid && host_own;
  assign copy_i.rvalid = mem_o.rvalid && !host_own;
  assign host_i.rdata  = host_own ? mem_o.rdata : '0;
  assign copy_i.rdata  = host_own ? '0 : mem_o.rdata;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      last_q     <= mst_idx_t'(COPY_IDX);
      owner_q    <= mst_idx_t'(HOST_IDX);
      wait_idx_q <= mst_idx_t'(HOST_IDX);
      wait_q     <= 1'b0;
      pend_q     <= 1'b0;
    end else begin
      wait_q     <= mem_o.req && !mem_o.gnt;
      wait_idx_q <= sel;
      if (mem_o.gnt) begin
        pend_q  <= 1'b1;
        owner_q <= sel;
        last_q  <= sel;
      end else if (mem_o.rvalid) begin
        pend_q <= 1'b0;
      end
    end
  end

  // The slave sees one master's request unchanged until it grants it
  a_sel_held: assert property (
    @(posedge clk_i) disable iff (reset_i)
    mem_o.req && !mem_o.gnt |=> mem_o.req && (sel == $past(sel)) && $stable(mem_o.addr)
  ) else $error("forwarded request changed before grant");

  a_no_gnt_pending: assert property (
    @(posedge clk_i) disable iff (reset_i) pend_q |-> !mem_o.gnt
  ) else $error("slave granted while a response is pending");

endmodule

// File: memcopy_periph.sv
// Memory copy engine with a single-cycle register port
// One word read then written per step; writes while busy are rejected
`timescale 1ns/1ps

module memcopy_periph
  import obi_pkg::*;
  import memcopy_pkg::*;
(
  input  logic         clk_i,
  input  logic         reset_i,
  input  logic         reg_valid_i,
  input  logic         reg_write_i,
  input  reg_addr_t    reg_addr_i,
  input  word_t        reg_wdata_i,
  output word_t        reg_rdata_o,
  output logic         reg_error_o,
  output logic         reg_ready_o,
  obi_if.master        master_o,
  output logic         memcopy_intr_o
);

  copy_state_e state_q;
  addr_t       src_q;
  addr_t       dst_q;
  word_t       size_q;
  word_t       buf_q;
  logic        done_q;
  logic        busy;
  logic        addr_ok;
  logic        wr_ok;
  logic        start;
  logic        status_rd;

  assign busy = (state_q != IDLE);

  always_comb begin
    addr_ok     = 1'b1;
    reg_rdata_o = '0;
    case (reg_addr_i)
      REG_SRC:    reg_rdata_o = src_q;
      REG_DST:    reg_rdata_o = dst_q;
      REG_SIZE:   reg_rdata_o = size_q;
      REG_STATUS: reg_rdata_o = {30'b0, done_q, busy};
      default:    addr_ok = 1'b0;
    endcase
  end

  // No wait states on the register port
  assign reg_ready_o = reg_valid_i;
  assign reg_error_o = reg_valid_i && (!addr_ok || (reg_write_i && busy));
  assign wr_ok       = reg_valid_i && reg_write_i && addr_ok && !busy;
  assign start       = wr_ok && (reg_addr_i == REG_SIZE);
  assign status_rd   = reg_valid_i && !reg_write_i && (reg_addr_i == REG_STATUS);

  assign master_o.req   = (state_q == RD_REQ) || (state_q == WR_REQ);
  assign master_o.we    = (state_q == WR_REQ);
  assign master_o.be    = '1;
  assign master_o.addr  = (state_q == WR_REQ) ? dst_q : src_q;
  assign master_o.wdata = buf_q;

  assign memcopy_intr_o = done_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= IDLE;
      src_q   <= '0;
      dst_q   <= '0;
      size_q  <= '0;
      done_q  <= 1'b0;
    end else begin
      if (status_rd) begin
        done_q <= 1'b0;
      end
      if (wr_ok && reg_addr_i == REG_SRC) begin
        src_q <= reg_wdata_i;
      end
      if (wr_ok && reg_addr_i == REG_DST) begin
        dst_q <= reg_wdata_i;
      end
      case (state_q)
        IDLE: begin
          if (start) begin
            size_q <= reg_wdata_i;
            if (reg_wdata_i == '0) begin
              done_q <= 1'b1;
            end else begin
              done_q  <= 1'b0;
              state_q <= RD_REQ;
            end
          end
        end
        RD_REQ: if (master_o.gnt) state_q <= RD_WAIT;
        RD_WAIT: if (master_o.rvalid) state_q <= WR_REQ;
        WR_REQ: if (master_o.gnt) state_q <= WR_WAIT;
        WR_WAIT: begin
          if (master_o.rvalid) begin
            src_q  <= src_q + 32'd4;
            dst_q  <= dst_q + 32'd4;
            size_q <= size_q - 32'd1;
            // Last word written
            if (size_q == 32'd1) begin
              state_q <= IDLE;
              done_q  <= 1'b1;
            end else begin
              state_q <= RD_REQ;
            end
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == RD_WAIT && master_o.rvalid) begin
      buf_q <= master_o.rdata;
    end
  end

  // Responses reach the engine only while it waits for one
  a_rvalid_expected: assert property (
    @(posedge clk_i) disable iff (reset_i)
    master_o.rvalid |-> (state_q == RD_WAIT) || (state_q == WR_WAIT)
  ) else $error("copy response arrived outside a wait state");

endmodule

// File: ext_subsystem.sv
// External device example: copy peripheral and host port share one slow RAM
// Host port follows OBI rules, one transaction at a time
`timescale 1ns/1ps

module ext_subsystem
  import obi_pkg::*;
  import memcopy_pkg::*;
(
  input  logic      clk_i,
  input  logic      reset_i,
  input  logic      reg_valid_i,
  input  logic      reg_write_i,
  input  reg_addr_t reg_addr_i,
  input  word_t     reg_wdata_i,
  output word_t     reg_rdata_o,
  output logic      reg_error_o,
  output logic      reg_ready_o,
  input  logic      host_req_i,
  input  logic      host_we_i,
  input  be_t       host_be_i,
  input  addr_t     host_addr_i,
  input  word_t     host_wdata_i,
  output logic      host_gnt_o,
  output logic      host_rvalid_o,
  output word_t     host_rdata_o,
  output logic      memcopy_intr_o
);

  obi_if host_bus ();
  obi_if copy_bus ();
  obi_if mem_bus ();

  // Host pins onto the arbiter's first master
  assign host_bus.req   = host_req_i;
  assign host_bus.we    = host_we_i;
  assign host_bus.be    = host_be_i;
  assign host_bus.addr  = host_addr_i;
  assign host_bus.wdata = host_wdata_i;
  assign host_gnt_o     = host_bus.gnt;
  assign host_rvalid_o  = host_bus.rvalid;
  assign host_rdata_o   = host_bus.rdata;

  memcopy_periph i_memcopy (
    .clk_i,
    .reset_i,
    .reg_valid_i,
    .reg_write_i,
    .reg_addr_i,
    .reg_wdata_i,
    .reg_rdata_o,
    .reg_error_o,
    .reg_ready_o,
    .master_o       (copy_bus),
    .memcopy_intr_o
  );

  obi_arbiter i_arbiter (
    .clk_i,
    .reset_i,
    .host_i  (host_bus),
    .copy_i  (copy_bus),
    .mem_o   (mem_bus)
  );

  slow_memory i_slow_ram (
    .clk_i,
    .reset_i,
    .bus_i   (mem_bus)
  );

endmodule

// File: tb_ext_subsystem.sv
// Table-driven testbench for ext_subsystem, inputs driven on the falling edge
// Outputs are sampled 1 ns after the falling edge, where they hold until the next rising edge
`timescale 1ns/1ps

module tb_ext_subsystem
  import obi_pkg::*;
  import memcopy_pkg::*;
();

  localparam int unsigned CLK_PERIOD   = 8;
  localparam int unsigned BUS_TIMEOUT  = 100;
  localparam int unsigned INTR_TIMEOUT = 1000;

  typedef enum logic [2:0] {OP_HWR, OP_HRD, OP_RWR, OP_RRD, OP_COPY, OP_WINT} op_e;

  typedef struct packed {
    op_e   op;
    addr_t addr;
    word_t data;
    be_t   be;
    logic  rnd;
  } step_t;

  logic      clk_i;
  logic      reset_i;
  logic      reg_valid_i;
  logic      reg_write_i;
  reg_addr_t reg_addr_i;
  word_t     reg_wdata_i;
  word_t     reg_rdata_o;
  logic      reg_error_o;
  logic      reg_ready_o;
  logic      host_req_i;
  logic      host_we_i;
  be_t       host_be_i;
  addr_t     host_addr_i;
  word_t     host_wdata_i;
  logic      host_gnt_o;
  logic      host_rvalid_o;
  word_t     host_rdata_o;
  logic      memcopy_intr_o;

  step_t       steps [$];
  word_t       ref_mem [MEM_WORDS];
  word_t       reg_model [4];
  logic        copy_active;
  logic        exp_done;
  logic        timed_out;
  logic [31:0] lfsr_q;
  int unsigned err_count;

  ext_subsystem i_dut (
    .clk_i, .reset_i, .reg_valid_i, .reg_write_i, .reg_addr_i, .reg_wdata_i,
    .reg_rdata_o, .reg_error_o, .reg_ready_o, .host_req_i, .host_we_i, .host_be_i,
    .host_addr_i, .host_wdata_i, .host_gnt_o, .host_rvalid_o, .host_rdata_o,
    .memcopy_intr_o
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // Fibonacci taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic next_rand_word(output word_t w);
    w = '0;
    for (int b = 0; b < 32; b++) begin
      lfsr_q = lfsr_step(lfsr_q);
      w = {w[30:0], lfsr_q[31]};
    end
  endtask

  function automatic word_t merge_bytes(input word_t old_w, input word_t new_w, input be_t be);
    word_t w;
    w = old_w;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) begin
        w[8*b +: 8] = new_w[8*b +: 8];
      end
    end
    return w;
  endfunction

  task automatic check_word(input word_t got, input word_t exp, input string what);
    if (got !== exp) begin
      $display("FAIL %0t: %s got %h, expected %h", $time, what, got, exp);
      err_count++;
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("FAIL %0t: %s got %b, expected %b", $time, what, got, exp);
      err_count++;
    end
  endtask

  task automatic add_step(input op_e op, input addr_t addr, input word_t data, input be_t be,
                          input logic rnd);
    step_t s;
    s = {op, addr, data, be, rnd};
    steps.push_back(s);
  endtask

  task automatic host_access(input logic we, input addr_t addr, input word_t wdata,
                             input be_t be, output word_t rdata);
    int unsigned cyc;
    rdata = '0;
    @(negedge clk_i);
    host_req_i   = 1'b1;
    host_we_i    = we;
    host_be_i    = be;
    host_addr_i  = addr;
    host_wdata_i = wdata;
    #1;
    cyc = 0;
    while (!host_gnt_o && cyc < BUS_TIMEOUT) begin
      @(negedge clk_i);
      #1;
      cyc++;
    end
    if (!host_gnt_o) begin
      $display("Timeout: host request to address %h was never granted", addr);
      timed_out = 1'b1;
      return;
    end
    // Address phase ends on the coming rising edge
    @(negedge clk_i);
    host_req_i = 1'b0;
    #1;
    cyc = 0;
    while (!host_rvalid_o && cyc < BUS_TIMEOUT) begin
      @(negedge clk_i);
      #1;
      cyc++;
    end
    if (!host_rvalid_o) begin
      $display("Timeout: no host response for address %h", addr);
      timed_out = 1'b1;
      return;
    end
    rdata = host_rdata_o;
  endtask

  task automatic reg_access(input logic wr, input reg_addr_t off, input word_t wdata,
                            output word_t rdata, output logic err, output logic rdy);
    @(negedge clk_i);
    reg_valid_i = 1'b1;
    reg_write_i = wr;
    reg_addr_i  = off;
    reg_wdata_i = wdata;
    #1;
    rdata = reg_rdata_o;
    err   = reg_error_o;
    rdy   = reg_ready_o;
    @(negedge clk_i);
    reg_valid_i = 1'b0;
    reg_write_i = 1'b0;
  endtask

  task automatic run_step(input step_t s);
    word_t       rdata;
    word_t       wdata;
    word_t       exp_reg;
    logic        err;
    logic        rdy;
    logic        exp_err;
    int unsigned idx;
    int unsigned cyc;
    idx   = s.addr[8:2];
    wdata = s.data;
    case (s.op)
      OP_HWR: begin
        if (s.rnd) begin
          next_rand_word(wdata);
        end
        host_access(1'b1, s.addr, wdata, s.be, rdata);
        ref_mem[idx] = merge_bytes(ref_mem[idx], wdata, s.be);
      end
      OP_HRD: begin
        host_access(1'b0, s.addr, '0, 4'hF, rdata);
        if (!timed_out) begin
          check_word(rdata, ref_mem[idx], $sformatf("host read at %h", s.addr));
        end
      end
      OP_WINT: begin
        cyc = 0;
        while (!memcopy_intr_o && cyc < INTR_TIMEOUT) begin
          @(negedge clk_i);
          #1;
          cyc++;
        end
        if (!memcopy_intr_o) begin
          $display("Timeout: copy interrupt was never raised");
          timed_out = 1'b1;
        end else begin
          copy_active = 1'b0;
          exp_done    = 1'b1;
        end
      end
      default: begin
        // Unmapped offsets and writes during a copy are rejected
        exp_err = (s.addr[1:0] != 2'b00) || (s.op != OP_RRD && copy_active);
        reg_access(s.op != OP_RRD, s.addr[3:0], wdata, rdata, err, rdy);
        check_flag(rdy, 1'b1, "register ready");
        check_flag(err, exp_err, $sformatf("register error at offset %h", s.addr[3:0]));
        if (s.op == OP_RRD && !exp_err) begin
          exp_reg = (s.addr[3:0] == REG_STATUS) ? {30'b0, exp_done, copy_active}
                                                 : reg_model[s.addr[3:2]];
          check_word(rdata, exp_reg, $sformatf("register read at %h", s.addr[3:0]));
          if (s.addr[3:0] == REG_STATUS) begin
            exp_done = 1'b0;
            #1;
            check_flag(memcopy_intr_o, 1'b0, "interrupt after status read");
          end
        end else if (s.op == OP_RWR && !exp_err) begin
          reg_model[s.addr[3:2]] = wdata;
        end else if (s.op == OP_COPY && !exp_err) begin
          for (int i = 0; i < int'(wdata); i++) begin
            ref_mem[reg_model[1][8:2] + i] = ref_mem[reg_model[0][8:2] + i];
          end
          reg_model[0] = reg_model[0] + 4 * wdata;
          reg_model[1] = reg_model[1] + 4 * wdata;
          reg_model[2] = '0;
          copy_active  = (wdata != '0);
          exp_done     = (wdata == '0);
        end
      end
    endcase
  endtask

  task automatic build_table();
    add_step(OP_RRD,  REG_STATUS, '0,            4'h0, 1'b0);
    add_step(OP_HWR,  32'h000,    32'h11223344, 4'hF, 1'b0);
    add_step(OP_HWR,  32'h000,    32'haabbccdd, 4'h5, 1'b0);
    add_step(OP_HRD,  32'h000,    '0,            4'hF, 1'b0);
    add_step(OP_HWR,  32'h004,    32'hcafef00d, 4'hF, 1'b0);
    add_step(OP_HWR,  32'h004,    32'h12345678, 4'h8, 1'b0);
    add_step(OP_HRD,  32'h004,    '0,            4'hF, 1'b0);
    add_step(OP_RWR,  REG_SRC,    32'h040,      4'h0, 1'b0);
    add_step(OP_RWR,  REG_DST,    32'h100,      4'h0, 1'b0);
    add_step(OP_RRD,  REG_SRC,    '0,            4'h0, 1'b0);
    add_step(OP_RRD,  REG_DST,    '0,            4'h0, 1'b0);
    add_step(OP_RRD,  32'h2,      '0,            4'h0, 1'b0);
    add_step(OP_HWR,  32'h040,    '0,            4'hF, 1'b1);
    add_step(OP_HWR,  32'h044,    '0,            4'hF, 1'b1);
    add_step(OP_HWR,  32'h048,    '0,            4'hF, 1'b1);
    add_step(OP_COPY, REG_SIZE,   32'd3,        4'h0, 1'b0);
    add_step(OP_RWR,  REG_SRC,    32'h080,      4'h0, 1'b0);
    add_step(OP_HRD,  32'h000,    '0,            4'hF, 1'b0);
    add_step(OP_HRD,  32'h004,    '0,            4'hF, 1'b0);
    add_step(OP_WINT, '0,         '0,            4'h0, 1'b0);
    add_step(OP_RRD,  REG_STATUS, '0,            4'h0, 1'b0);
    add_step(OP_RRD,  REG_SRC,    '0,            4'h0, 1'b0);
    add_step(OP_HRD,  32'h100,    '0,            4'hF, 1'b0);
    add_step(OP_HRD,  32'h104,    '0,            4'hF, 1'b0);
    add_step(OP_HRD,  32'h108,    '0,            4'hF, 1'b0);
    add_step(OP_COPY, REG_SIZE,   32'd0,        4'h0, 1'b0);
    add_step(OP_WINT, '0,         '0,            4'h0, 1'b0);
    add_step(OP_RRD,  REG_STATUS, '0,            4'h0, 1'b0);
    add_step(OP_RRD,  REG_SIZE,   '0,            4'h0, 1'b0);
    add_step(OP_HRD,  32'h100,    '0,            4'hF, 1'b0);
  endtask

  initial begin
    int unsigned steps_run;
    int unsigned errs_before;
    reset_i      = 1'b1;
    reg_valid_i  = 1'b0;
    reg_write_i  = 1'b0;
    reg_addr_i   = '0;
    reg_wdata_i  = '0;
    host_req_i   = 1'b0;
    host_we_i    = 1'b0;
    host_be_i    = '0;
    host_addr_i  = '0;
    host_wdata_i = '0;
    lfsr_q       = 32'h061dd961;
    err_count    = 0;
    steps_run    = 0;
    timed_out    = 1'b0;
    copy_active  = 1'b0;
    exp_done     = 1'b0;
    reg_model    = '{default: '0};
    build_table();
    repeat (2) @(negedge clk_i);
    reset_i = 1'b0;
    #1;
    check_flag(memcopy_intr_o, 1'b0, "interrupt after reset");
    check_flag(host_gnt_o, 1'b0, "host gnt after reset");
    check_flag(host_rvalid_o, 1'b0, "host rvalid after reset");
    foreach (steps[i]) begin
      if (!timed_out) begin
        errs_before = err_count;
        run_step(steps[i]);
        steps_run++;
        $display("step %0d %s: %s", i, steps[i].op.name(),
                 (err_count == errs_before && !timed_out) ? "ok" : "mismatch");
      end
    end
    $display("%0d of %0d steps run, %0d errors", steps_run, steps.size(), err_count);
    if (err_count == 0 && !timed_out) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// File: list.f
obi_pkg.sv
memcopy_pkg.sv
obi_if.sv
slow_memory.sv
obi_arbiter.sv
memcopy_periph.sv
ext_subsystem.sv
tb_ext_subsystem.sv

// File: Bender.yml
package:
  name: ext_subsystem

sources:
  - obi_pkg.sv
  - memcopy_pkg.sv
  - obi_if.sv
  - slow_memory.sv
  - obi_arbiter.sv
  - memcopy_periph.sv
  - ext_subsystem.sv
  - target: test
    files:
      - tb_ext_subsystem.sv
